// ==== program_stimulus.txt ====
# P instr_word | D byte_addr data_word | S byte_addr lane_data byte_enable | L byte_addr
# hex values, P lines fill instruction memory from address 0, S and L in expected order
D 00000000 80F17F82
P 123452B7
P 67828293
P 00001317
P 006283B3
P 40538433
P FFF44493
P 4044D513
P 005525B3
P 00553633
P 00B296B3
P 00C6E733
P 08702023
P 08802223
P 08A02423
P 08B02623
P 08C02823
P 08E02A23
P 00004083
P 04100823
P 00104083
P 041008A3
P 00204083
P 04100923
P 00304083
P 04102E23
P 00000083
P 06102023
P 00100083
P 06102223
P 00200083
P 06102423
P 00300083
P 041009A3
P 00001083
P 06102623
P 00201083
P 06102823
P 00005083
P 04101B23
P 00205083
P 06102A23
P 00002083
P 04101A23
P 00A28663
P 0C002023
P 00528463
P 0E002E23
P 00529663
P 0C002223
P 00A29463
P 0E002E23
P 00A2C663
P 0C002423
P 00554463
P 0E002E23
P 00555663
P 0C002623
P 00A2D463
P 0E002E23
P 00556663
P 0C002823
P 00A2E463
P 0E002E23
P 00A2F663
P 0C002A23
P 00557463
P 0E002E23
P 00C007EF
P 0E002E23
P 0E002E23
P 0AF02023
P 13000813
P 004808E7
P 0E002E23
P 0E002E23
P 0E002E23
P 0E002E23
P 0B102223
P 0000006F
S 00000080 12346680 F
S 00000084 00001008 F
S 00000088 FFFFFEFF F
S 0000008C 00000001 F
S 00000090 00000000 F
S 00000094 2468ACF0 F
L 00000000
S 00000050 00000082 1
L 00000000
S 00000050 00007F00 2
L 00000000
S 00000050 00F10000 4
L 00000000
S 0000005C 00000080 F
L 00000000
S 00000060 FFFFFF82 F
L 00000000
S 00000064 0000007F F
L 00000000
S 00000068 FFFFFFF1 F
L 00000000
S 00000050 80000000 8
L 00000000
S 0000006C 00007F82 F
L 00000000
S 00000070 FFFF80F1 F
L 00000000
S 00000054 7F820000 C
L 00000000
S 00000074 000080F1 F
L 00000000
S 00000054 00007F82 3
S 000000C0 00000000 F
S 000000C4 00000000 F
S 000000C8 00000000 F
S 000000CC 00000000 F
S 000000D0 00000000 F
S 000000D4 00000000 F
S 000000A0 00000110 F
S 000000A4 00000124 F

// ==== files.f ====
rv32i_pkg.sv
pipe_if.sv
instr_decode.sv
regfile.sv
execute_unit.sv
hazard_unit.sv
datapath.sv
datapath_checker.sv
tb_datapath.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the datapath testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -sv -f files.f \
    --top-module tb_datapath -o tb_datapath_sim \
    && ./obj_dir/tb_datapath_sim | tee /dev/stderr | grep -qF '*** PASSED ***' \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== tb_datapath.sv ====
`timescale 1ns/100ps

module tb_datapath;
    import rv32i_pkg::*;

    localparam int imem_words = 128;
    localparam int dmem_words = 64;
    localparam int cycles_per_item = 40;

    typedef struct packed {
        logic      is_store;
        rv32i_word addr;
        rv32i_word data;
        byte_en_t  be;
    } access_t;

    logic      clk;
    logic      reset;
    rv32i_word imem_rdata;
    rv32i_word imem_address;
    rv32i_word dmem_rdata;
    rv32i_word dmem_address;
    rv32i_word dmem_wdata;
    logic      dmem_read;
    logic      dmem_write;
    byte_en_t  dmem_byte_enable;

    rv32i_word imem [imem_words];
    rv32i_word dmem [dmem_words];
    access_t   expected [$];
    int        next_idx;
    int        n_prog;
    int        seed;

    datapath u_datapath (
        .clk              (clk),
        .reset            (reset),
        .imem_rdata       (imem_rdata),
        .imem_address     (imem_address),
        .dmem_rdata       (dmem_rdata),
        .dmem_address     (dmem_address),
        .dmem_wdata       (dmem_wdata),
        .dmem_read        (dmem_read),
        .dmem_write       (dmem_write),
        .dmem_byte_enable (dmem_byte_enable)
    );

    // both memories answer within the cycle
    assign imem_rdata = imem[imem_address[8:2]];
    assign dmem_rdata = dmem[dmem_address[7:2]];

    always #4 clk = ~clk;

    task automatic abort_run(string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "run stopped");
    endtask

    function automatic rv32i_word lane_mask(byte_en_t be);
        rv32i_word mask;
        for (int i = 0; i < 4; i++) begin
            mask[i*8 +: 8] = {8{be[i]}};
        end
        return mask;
    endfunction

    task automatic check_fetch_addr(rv32i_word addr);
        if (addr !== reset_pc) begin
            abort_run($sformatf("mismatch at %0t: first fetch at %h, expected %h",
                                $time, addr, reset_pc));
        end
    endtask

    task automatic check_store(rv32i_word addr, rv32i_word data, byte_en_t be);
        access_t   exp;
        rv32i_word mask;
        if (next_idx >= expected.size()) begin
            abort_run($sformatf("store to %h at %0t after all expected accesses", addr, $time));
        end else begin
            exp = expected[next_idx];
            mask = lane_mask(exp.be);
            if (!exp.is_store) begin
                abort_run($sformatf("a store to %h came at %0t where a load was expected",
                                    addr, $time));
            end else if (addr !== exp.addr || be !== exp.be
                         || (data & mask) !== (exp.data & mask)) begin
                abort_run($sformatf({"mismatch at %0t: store %h data %h be %b, ",
                                     "expected %h data %h be %b"},
                                    $time, addr, data, be, exp.addr, exp.data, exp.be));
            end else begin
                next_idx++;
            end
        end
    endtask

    task automatic check_load_addr(rv32i_word addr);
        access_t exp;
        if (next_idx >= expected.size()) begin
            abort_run($sformatf("load from %h at %0t after all expected accesses", addr, $time));
        end else begin
            exp = expected[next_idx];
            if (exp.is_store) begin
                abort_run($sformatf("a load from %h came at %0t where a store was expected",
                                    addr, $time));
            end else if (addr !== exp.addr) begin
                abort_run($sformatf("mismatch at %0t: load address %h, expected %h",
                                    $time, addr, exp.addr));
            end else begin
                next_idx++;
            end
        end
    endtask

    task automatic write_lanes(rv32i_word addr, rv32i_word data, byte_en_t be);
        rv32i_word mask;
        mask = lane_mask(be);
        dmem[addr[7:2]] = (dmem[addr[7:2]] & ~mask) | (data & mask);
    endtask

    task automatic parse_record(string line);
        string     tag;
        rv32i_word a;
        rv32i_word b;
        rv32i_word c;
        int        n;
        n = $sscanf(line, "%s %h %h %h", tag, a, b, c);
        case (tag)
            "P": begin
                imem[n_prog[6:0]] = a;
                n_prog++;
            end
            "D": dmem[a[7:2]] = b;
            "S": expected.push_back('{1'b1, a, b, c[3:0]});
            "L": expected.push_back('{1'b0, a, 32'h0, 4'h0});
            default: abort_run($sformatf("bad stimulus line with %0d fields: %s", n, line));
        endcase
    endtask

    task automatic load_stimulus();
        int    fd;
        int    n;
        string line;
        for (int i = 0; i < imem_words; i++) begin
            imem[i[6:0]] = nop_instr;
        end
        // unused data words get noise so stray loads show up
        for (int i = 0; i < dmem_words; i++) begin
            dmem[i[5:0]] = $random(seed);
        end
        fd = $fopen("program_stimulus.txt", "r");
        if (fd == 0) begin
            abort_run("could not open program_stimulus.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line[0] != "#") begin
                parse_record(line);
            end
        end
        $fclose(fd);
    endtask

    // memory side of every access, sampled mid-cycle
    always @(negedge clk) begin
        if (dmem_write === 1'b1) begin
            check_store(dmem_address, dmem_wdata, dmem_byte_enable);
            write_lanes(dmem_address, dmem_wdata, dmem_byte_enable);
        end
        if (dmem_read === 1'b1) begin
            check_load_addr(dmem_address);
        end
    end

    initial begin
        #1;
        repeat ((n_prog + expected.size()) * cycles_per_item) @(posedge clk);
        abort_run($sformatf("timeout with %0d of %0d accesses seen",
                            next_idx, expected.size()));
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        next_idx = 0;
        n_prog = 0;
        seed = 32'h4e79_ed72;
        load_stimulus();
        repeat (5) @(posedge clk);
        @(negedge clk);
        check_fetch_addr(imem_address);
        reset = 1'b0;
        while (next_idx < expected.size()) begin
            @(posedge clk);
        end
        // a few more cycles to catch anything past the last access
        repeat (16) @(negedge clk);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== datapath_checker.sv ====
`timescale 1ns/100ps

module datapath_checker (
    input logic                 clk,
    input logic                 reset,
    input logic                 dmem_read,
    input logic                 dmem_write,
    input rv32i_pkg::byte_en_t  dmem_byte_enable,
    input rv32i_pkg::rv32i_word imem_address
);

    a_strobes_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(dmem_read && dmem_write))
        else $error("read and write strobes high together");

    // one reset edge clears the memory stage controls
    a_quiet_in_reset: assert property (@(posedge clk)
        $past(reset) |-> !dmem_read && !dmem_write)
        else $error("memory strobe during reset");

    a_write_has_enable: assert property (@(posedge clk) disable iff (reset)
        dmem_write |-> dmem_byte_enable != 4'b0000)
        else $error("write with no byte enable");

    a_fetch_aligned: assert property (@(posedge clk) disable iff (reset)
        imem_address[1:0] == 2'b00)
        else $error("fetch address not word aligned");

endmodule

bind datapath datapath_checker u_checker (
    .clk              (clk),
    .reset            (reset),
    .dmem_read        (dmem_read),
    .dmem_write       (dmem_write),
    .dmem_byte_enable (dmem_byte_enable),
    .imem_address     (imem_address)
);

// ==== datapath.sv ====
`timescale 1ns/100ps

module datapath (
    input  logic                 clk,
    input  logic                 reset,
    input  rv32i_pkg::rv32i_word imem_rdata,
    output rv32i_pkg::rv32i_word imem_address,
    input  rv32i_pkg::rv32i_word dmem_rdata,
    output rv32i_pkg::rv32i_word dmem_address,
    output rv32i_pkg::rv32i_word dmem_wdata,
    output logic                 dmem_read,
    output logic                 dmem_write,
    output rv32i_pkg::byte_en_t  dmem_byte_enable
);
    import rv32i_pkg::*;

    pipe_if if_id ();
    pipe_if id_ex ();
    pipe_if ex_mem ();
    pipe_if mem_wb ();

    rv32i_word  pc;

    // decode
    ctrl_word_t id_ctrl;
    rv32i_word  id_imm;
    rv32i_word  id_rs1_val;
    rv32i_word  id_rs2_val;
    reg_idx_t   id_rs1;
    reg_idx_t   id_rs2;

    // execute
    rv32i_word  ex_result;
    rv32i_word  ex_store_val;
    rv32i_word  ex_target;
    logic       ex_redirect;
    fwd_sel_t   fwd_a;
    fwd_sel_t   fwd_b;
    logic       stall;
    logic       flush;

    // memory and writeback
    logic [1:0] mem_offset;
    rv32i_word  load_shifted;
    rv32i_word  load_val;
    rv32i_word  wb_data;

    // fetch
    assign imem_address = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (flush) begin
            pc <= ex_target;
        end else if (!stall) begin
            pc <= pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            if_id.instr <= nop_instr;
        end else if (!stall) begin
            if_id.instr <= imem_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if_id.pc <= pc;
            if_id.pc_plus4 <= pc + 32'd4;
        end
    end

    instr_decode u_decode (
        .instr (if_id.instr),
        .ctrl  (id_ctrl),
        .imm   (id_imm),
        .rs1   (id_rs1),
        .rs2   (id_rs2),
        .rd    ()
    );

    regfile u_regfile (
        .clk     (clk),
        .reset   (reset),
        .we      (mem_wb.ctrl.reg_write),
        .waddr   (mem_wb.instr.r_view.rd),
        .wdata   (wb_data),
        .raddr_a (id_rs1),
        .raddr_b (id_rs2),
        .rdata_a (id_rs1_val),
        .rdata_b (id_rs2_val)
    );

    // a stalled instruction stays in decode and execute gets a bubble
    always_ff @(posedge clk) begin
        if (reset || flush || stall) begin
            id_ex.ctrl <= nop_ctrl;
        end else begin
            id_ex.ctrl <= id_ctrl;
        end
    end

    always_ff @(posedge clk) begin
        id_ex.pc <= if_id.pc;
        id_ex.pc_plus4 <= if_id.pc_plus4;
        id_ex.instr <= if_id.instr;
        id_ex.imm <= id_imm;
        id_ex.rs1_val <= id_rs1_val;
        id_ex.rs2_val <= id_rs2_val;
    end

    execute_unit u_execute (
        .id_ex      (id_ex),
        .mem_result (ex_mem.result),
        .wb_result  (wb_data),
        .fwd_a      (fwd_a),
        .fwd_b      (fwd_b),
        .result     (ex_result),
        .store_val  (ex_store_val),
        .redirect   (ex_redirect),
        .target     (ex_target)
    );

    hazard_unit u_hazard (
        .id_rs1        (id_rs1),
        .id_rs2        (id_rs2),
        .ex_rs1        (id_ex.instr.r_view.rs1),
        .ex_rs2        (id_ex.instr.r_view.rs2),
        .ex_rd         (id_ex.instr.r_view.rd),
        .mem_rd        (ex_mem.instr.r_view.rd),
        .wb_rd         (mem_wb.instr.r_view.rd),
        .ex_mem_read   (id_ex.ctrl.mem_read),
        .mem_reg_write (ex_mem.ctrl.reg_write),
        .wb_reg_write  (mem_wb.ctrl.reg_write),
        .redirect      (ex_redirect),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b),
        .stall         (stall),
        .flush         (flush)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_mem.ctrl <= nop_ctrl;
        end else begin
            ex_mem.ctrl <= id_ex.ctrl;
        end
    end

    always_ff @(posedge clk) begin
        ex_mem.instr <= id_ex.instr;
        ex_mem.result <= ex_result;
        ex_mem.rs2_val <= ex_store_val;
    end

    // memory stage
    assign dmem_read = ex_mem.ctrl.mem_read;
    assign dmem_write = ex_mem.ctrl.mem_write;
    assign dmem_address = {ex_mem.result[31:2], 2'b00};
    assign mem_offset = ex_mem.result[1:0];

    // replicate the narrow value into every lane, the enables pick one
    always_comb begin
        case (ex_mem.ctrl.funct3)
            f3_sb: begin
                dmem_byte_enable = 4'b0001 << mem_offset;
                dmem_wdata = {4{ex_mem.rs2_val[7:0]}};
            end
            f3_sh: begin
                dmem_byte_enable = 4'b0011 << {mem_offset[1], 1'b0};
                dmem_wdata = {2{ex_mem.rs2_val[15:0]}};
            end
            default: begin
                dmem_byte_enable = 4'b1111;
                dmem_wdata = ex_mem.rs2_val;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_wb.ctrl <= nop_ctrl;
        end else begin
            mem_wb.ctrl <= ex_mem.ctrl;
        end
    end

    always_ff @(posedge clk) begin
        mem_wb.instr <= ex_mem.instr;
        mem_wb.result <= ex_mem.result;
        mem_wb.load_data <= dmem_rdata;
    end

    // writeback, bring the addressed lane down to bit 0 first
    assign load_shifted = mem_wb.load_data >> {mem_wb.result[1:0], 3'b000};

    always_comb begin
        case (mem_wb.ctrl.funct3)
            f3_lb:   load_val = {{24{load_shifted[7]}}, load_shifted[7:0]};
            f3_lh:   load_val = {{16{load_shifted[15]}}, load_shifted[15:0]};
            f3_lbu:  load_val = {24'b0, load_shifted[7:0]};
            f3_lhu:  load_val = {16'b0, load_shifted[15:0]};
            default: load_val = mem_wb.load_data;
        endcase
    end

    // jal and jalr already carry pc_plus4 in result
    always_comb begin
        case (mem_wb.ctrl.wb_sel)
            wb_load: wb_data = load_val;
            default: wb_data = mem_wb.result;
        endcase
    end

endmodule

// ==== hazard_unit.sv ====
`timescale 1ns/100ps

module hazard_unit (
    input  rv32i_pkg::reg_idx_t id_rs1,
    input  rv32i_pkg::reg_idx_t id_rs2,
    input  rv32i_pkg::reg_idx_t ex_rs1,
    input  rv32i_pkg::reg_idx_t ex_rs2,
    input  rv32i_pkg::reg_idx_t ex_rd,
    input  rv32i_pkg::reg_idx_t mem_rd,
    input  rv32i_pkg::reg_idx_t wb_rd,
    input  logic                ex_mem_read,
    input  logic                mem_reg_write,
    input  logic                wb_reg_write,
    input  logic                redirect,
    output rv32i_pkg::fwd_sel_t fwd_a,
    output rv32i_pkg::fwd_sel_t fwd_b,
    output logic                stall,
    output logic                flush
);
    import rv32i_pkg::*;

    // the younger producer in memory wins over writeback
    function automatic fwd_sel_t fwd_for(reg_idx_t src);
        if (src == 5'd0) begin
            return fwd_regfile;
        end
        if (mem_reg_write && mem_rd == src) begin
            return fwd_mem;
        end
        if (wb_reg_write && wb_rd == src) begin
            return fwd_wb;
        end
        return fwd_regfile;
    endfunction

    always_comb begin
        fwd_a = fwd_for(ex_rs1);
        fwd_b = fwd_for(ex_rs2);
    end

    // load data is only ready in writeback, so hold the consumer one cycle
    assign stall = ex_mem_read && ex_rd != 5'd0
                   && (ex_rd == id_rs1 || ex_rd == id_rs2);
    assign flush = redirect;

endmodule

// ==== execute_unit.sv ====
`timescale 1ns/100ps

module execute_unit (
    pipe_if.downstream           id_ex,
    input  rv32i_pkg::rv32i_word mem_result,
    input  rv32i_pkg::rv32i_word wb_result,
    input  rv32i_pkg::fwd_sel_t  fwd_a,
    input  rv32i_pkg::fwd_sel_t  fwd_b,
    output rv32i_pkg::rv32i_word result,
    output rv32i_pkg::rv32i_word store_val,
    output logic                 redirect,
    output rv32i_pkg::rv32i_word target
);
    import rv32i_pkg::*;

    rv32i_word rs1_fwd;
    rv32i_word rs2_fwd;
    rv32i_word op_a;
    rv32i_word op_b;
    rv32i_word alu_out;
    rv32i_word jalr_sum;
    logic      taken;

    function automatic rv32i_word pick_operand(fwd_sel_t sel, rv32i_word rf_val,
                                               rv32i_word mem_val, rv32i_word wb_val);
        case (sel)
            fwd_mem: return mem_val;
            fwd_wb:  return wb_val;
            default: return rf_val;
        endcase
    endfunction

    assign rs1_fwd = pick_operand(fwd_a, id_ex.rs1_val, mem_result, wb_result);
    assign rs2_fwd = pick_operand(fwd_b, id_ex.rs2_val, mem_result, wb_result);
    assign op_a = id_ex.ctrl.src_a_is_pc ? id_ex.pc : rs1_fwd;
    assign op_b = id_ex.ctrl.src_b_is_imm ? id_ex.imm : rs2_fwd;
    assign store_val = rs2_fwd;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            alu_add:  alu_out = op_a + op_b;
            alu_sub:  alu_out = op_a - op_b;
            alu_sll:  alu_out = op_a << op_b[4:0];
            alu_slt:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            alu_sltu: alu_out = {31'b0, op_a < op_b};
            alu_xor:  alu_out = op_a ^ op_b;
            alu_srl:  alu_out = op_a >> op_b[4:0];
            alu_sra:  alu_out = $signed(op_a) >>> op_b[4:0];
            alu_or:   alu_out = op_a | op_b;
            alu_and:  alu_out = op_a & op_b;
            default:  alu_out = op_b;
        endcase
    end

    always_comb begin
        case (id_ex.ctrl.funct3)
            f3_beq:  taken = (rs1_fwd == rs2_fwd);
            f3_bne:  taken = (rs1_fwd != rs2_fwd);
            f3_blt:  taken = ($signed(rs1_fwd) < $signed(rs2_fwd));
            f3_bge:  taken = ($signed(rs1_fwd) >= $signed(rs2_fwd));
            f3_bltu: taken = (rs1_fwd < rs2_fwd);
            f3_bgeu: taken = (rs1_fwd >= rs2_fwd);
            default: taken = 1'b0;
        endcase
    end

    // link value leaves execute already so it can be forwarded from memory
    assign result = (id_ex.ctrl.wb_sel == wb_pc_plus4) ? id_ex.pc_plus4 : alu_out;

    assign redirect = id_ex.ctrl.is_jal || id_ex.ctrl.is_jalr
                      || (id_ex.ctrl.is_branch && taken);
    assign jalr_sum = rs1_fwd + id_ex.imm;
    assign target = id_ex.ctrl.is_jalr ? {jalr_sum[31:1], 1'b0} : id_ex.pc + id_ex.imm;

endmodule

// ==== regfile.sv ====
`timescale 1ns/100ps

module regfile (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 we,
    input  rv32i_pkg::reg_idx_t  waddr,
    input  rv32i_pkg::rv32i_word wdata,
    input  rv32i_pkg::reg_idx_t  raddr_a,
    input  rv32i_pkg::reg_idx_t  raddr_b,
    output rv32i_pkg::rv32i_word rdata_a,
    output rv32i_pkg::rv32i_word rdata_b
);
    import rv32i_pkg::*;

    rv32i_word regs [32];

    // writeback in the same cycle is visible to decode
    function automatic rv32i_word read_port(reg_idx_t addr);
        if (addr == 5'd0) begin
            return '0;
        end
        if (we && waddr == addr) begin
            return wdata;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    always_comb begin
        rdata_a = read_port(raddr_a);
        rdata_b = read_port(raddr_b);
    end

endmodule

// ==== instr_decode.sv ====
`timescale 1ns/100ps

module instr_decode (
    input  rv32i_pkg::instr_u     instr,
    output rv32i_pkg::ctrl_word_t ctrl,
    output rv32i_pkg::rv32i_word  imm,
    output rv32i_pkg::reg_idx_t   rs1,
    output rv32i_pkg::reg_idx_t   rs2,
    output rv32i_pkg::reg_idx_t   rd
);
    import rv32i_pkg::*;

    rv32i_word i_imm;
    rv32i_word s_imm;
    rv32i_word b_imm;
    rv32i_word u_imm;
    rv32i_word j_imm;
    logic      writes_rd;

    function automatic alu_op_t alu_from_funct3(funct3_t f3, logic alt);
        case (f3)
            f3_add:  return alt ? alu_sub : alu_add;
            f3_sll:  return alu_sll;
            f3_slt:  return alu_slt;
            f3_sltu: return alu_sltu;
            f3_xor:  return alu_xor;
            f3_sr:   return alt ? alu_sra : alu_srl;
            f3_or:   return alu_or;
            default: return alu_and;
        endcase
    endfunction

    assign i_imm = {{20{instr.i_view.imm12[11]}}, instr.i_view.imm12};
    // S and B split their immediate across the funct7 and rd fields
    assign s_imm = {{20{instr.r_view.funct7[6]}}, instr.r_view.funct7, instr.r_view.rd};
    assign b_imm = {{20{instr.r_view.funct7[6]}}, instr.r_view.rd[0],
                    instr.r_view.funct7[5:0], instr.r_view.rd[4:1], 1'b0};
    assign u_imm = {instr.r_view.funct7, instr.r_view.rs2, instr.r_view.rs1,
                    instr.r_view.funct3, 12'h000};
    assign j_imm = {{12{instr.r_view.funct7[6]}}, instr.r_view.rs1, instr.r_view.funct3,
                    instr.r_view.rs2[0], instr.r_view.funct7[5:0], instr.r_view.rs2[4:1], 1'b0};

    assign rd = instr.r_view.rd;
    // x0 targets never count as a register write
    assign writes_rd = (instr.r_view.rd != 5'd0);

    always_comb begin
        ctrl = nop_ctrl;
        ctrl.funct3 = instr.r_view.funct3;
        imm = i_imm;
        // sources that a format does not read stay at x0 to avoid false stalls
        rs1 = instr.r_view.rs1;
        rs2 = 5'd0;
        case (instr.r_view.opcode)
            opc_op: begin
                ctrl.alu_op = alu_from_funct3(instr.r_view.funct3, instr.r_view.funct7[5]);
                ctrl.reg_write = writes_rd;
                rs2 = instr.r_view.rs2;
            end
            opc_op_imm: begin
                // bit 30 only matters for srai
                ctrl.alu_op = alu_from_funct3(instr.r_view.funct3,
                    instr.r_view.funct7[5] && instr.r_view.funct3 == f3_sr);
                ctrl.src_b_is_imm = 1'b1;
                ctrl.reg_write = writes_rd;
            end
            opc_lui: begin
                ctrl.alu_op = alu_pass_b;
                ctrl.src_b_is_imm = 1'b1;
                ctrl.reg_write = writes_rd;
                imm = u_imm;
                rs1 = 5'd0;
            end
            opc_auipc: begin
                ctrl.src_a_is_pc = 1'b1;
                ctrl.src_b_is_imm = 1'b1;
                ctrl.reg_write = writes_rd;
                imm = u_imm;
                rs1 = 5'd0;
            end
            opc_jal: begin
                ctrl.is_jal = 1'b1;
                ctrl.reg_write = writes_rd;
                ctrl.wb_sel = wb_pc_plus4;
                imm = j_imm;
                rs1 = 5'd0;
            end
            opc_jalr: begin
                ctrl.is_jalr = 1'b1;
                ctrl.reg_write = writes_rd;
                ctrl.wb_sel = wb_pc_plus4;
            end
            opc_branch: begin
                ctrl.is_branch = 1'b1;
                imm = b_imm;
                rs2 = instr.r_view.rs2;
            end
            opc_load: begin
                ctrl.src_b_is_imm = 1'b1;
                ctrl.mem_read = 1'b1;
                ctrl.reg_write = writes_rd;
                ctrl.wb_sel = wb_load;
            end
            opc_store: begin
                ctrl.src_b_is_imm = 1'b1;
                ctrl.mem_write = 1'b1;
                imm = s_imm;
                rs2 = instr.r_view.rs2;
            end
            default: begin
                ctrl = nop_ctrl;
                rs1 = 5'd0;
            end
        endcase
    end

endmodule

// ==== pipe_if.sv ====
`timescale 1ns/100ps

interface pipe_if;
    import rv32i_pkg::*;

    rv32i_word  pc;
    rv32i_word  pc_plus4;
    instr_u     instr;
    ctrl_word_t ctrl;
    rv32i_word  imm;
    rv32i_word  rs1_val;
    // also carries the store data past execute
    rv32i_word  rs2_val;
    rv32i_word  result;
    rv32i_word  load_data;

    modport upstream (
        output pc, pc_plus4, instr, ctrl, imm,
        output rs1_val, rs2_val, result, load_data
    );

    modport downstream (
        input pc, pc_plus4, instr, ctrl, imm,
        input rs1_val, rs2_val, result, load_data
    );

endinterface

// ==== rv32i_pkg.sv ====
package rv32i_pkg;

    typedef logic [31:0] rv32i_word;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  byte_en_t;
    typedef logic [2:0]  funct3_t;

    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011
    } opcode_t;

    // alu kinds, bit 30 picks sub and sra
    localparam funct3_t f3_add  = 3'b000;
    localparam funct3_t f3_sll  = 3'b001;
    localparam funct3_t f3_slt  = 3'b010;
    localparam funct3_t f3_sltu = 3'b011;
    localparam funct3_t f3_xor  = 3'b100;
    localparam funct3_t f3_sr   = 3'b101;
    localparam funct3_t f3_or   = 3'b110;
    localparam funct3_t f3_and  = 3'b111;

    // branch conditions
    localparam funct3_t f3_beq  = 3'b000;
    localparam funct3_t f3_bne  = 3'b001;
    localparam funct3_t f3_blt  = 3'b100;
    localparam funct3_t f3_bge  = 3'b101;
    localparam funct3_t f3_bltu = 3'b110;
    localparam funct3_t f3_bgeu = 3'b111;

    // load and store widths
    localparam funct3_t f3_lb  = 3'b000;
    localparam funct3_t f3_lh  = 3'b001;
    localparam funct3_t f3_lw  = 3'b010;
    localparam funct3_t f3_lbu = 3'b100;
    localparam funct3_t f3_lhu = 3'b101;
    localparam funct3_t f3_sb  = 3'b000;
    localparam funct3_t f3_sh  = 3'b001;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
    } alu_op_t;

    typedef enum logic [1:0] {wb_alu, wb_load, wb_pc_plus4} wb_sel_t;

    typedef enum logic [1:0] {fwd_regfile, fwd_mem, fwd_wb} fwd_sel_t;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        funct3_t    funct3;
        reg_idx_t   rd;
        opcode_t    opcode;
    } r_fields_t;

    typedef struct packed {
        logic [11:0] imm12;
        reg_idx_t    rs1;
        funct3_t     funct3;
        reg_idx_t    rd;
        opcode_t     opcode;
    } i_fields_t;

    typedef union packed {
        r_fields_t r_view;
        i_fields_t i_view;
    } instr_u;

    typedef struct packed {
        alu_op_t alu_op;
        logic    src_a_is_pc;
        logic    src_b_is_imm;
        logic    is_branch;
        logic    is_jal;
        logic    is_jalr;
        logic    mem_read;
        logic    mem_write;
        logic    reg_write;
        wb_sel_t wb_sel;
        funct3_t funct3;
    } ctrl_word_t;

    localparam rv32i_word reset_pc = 32'h0000_0000;

    // addi x0, x0, 0
    localparam rv32i_word nop_instr = 32'h0000_0013;

    localparam ctrl_word_t nop_ctrl = '{
        alu_op:       alu_add,
        src_a_is_pc:  1'b0,
        src_b_is_imm: 1'b0,
        is_branch:    1'b0,
        is_jal:       1'b0,
        is_jalr:      1'b0,
        mem_read:     1'b0,
        mem_write:    1'b0,
        reg_write:    1'b0,
        wb_sel:       wb_alu,
        funct3:       3'b000
    };

endpackage
